//--- common/mips_decode_consts.svh
`ifndef MIPS_DECODE_CONSTS_SVH
`define MIPS_DECODE_CONSTS_SVH

// instruction word and its fields
`define INST_W      32
`define OPC_MSB     31
`define OPC_LSB     26
`define REG_W       5
`define SHAMT_W     5
`define IMM_W       16
`define JT_W        26   // j/jal target index

// apb register map
`define APB_ADDR_W     8
`define APB_ADDR_INST  8'h00  // write only, pushes a word
`define APB_ADDR_STAT  8'h04  // read only, queue count in low bits

// instruction queue
`define QUEUE_DEPTH  8
`define QCNT_W       4    // holds 0..QUEUE_DEPTH

`endif

//--- common/mips_decode_pkg.sv
package mips_decode_pkg;

    // decoded operation handed to the back end
    typedef enum logic [7:0] {
        OP_INVALID = 8'h00,
        // branch and jump
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_J, OP_JAL, OP_JR, OP_JALR,
        // alu
        OP_ADD, OP_SLT, OP_AND, OP_OR, OP_XOR, OP_LU,
        OP_SUB, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
        // memory
        OP_LB, OP_LH, OP_LW, OP_LWL, OP_LWR,
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_CACHE,
        // cp0 and traps
        OP_MFC0, OP_MTC0, OP_ERET, OP_WAIT,
        OP_TLBWI, OP_TLBP, OP_SYSCALL, OP_BREAK
    } op_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00, OPC_REGIMM = 6'h01, OPC_J    = 6'h02, OPC_JAL   = 6'h03,
        OPC_BEQ     = 6'h04, OPC_BNE    = 6'h05, OPC_BLEZ = 6'h06, OPC_BGTZ  = 6'h07,
        OPC_ADDI    = 6'h08, OPC_ADDIU  = 6'h09, OPC_SLTI = 6'h0a, OPC_SLTIU = 6'h0b,
        OPC_ANDI    = 6'h0c, OPC_ORI    = 6'h0d, OPC_XORI = 6'h0e, OPC_LUI   = 6'h0f,
        OPC_COP0    = 6'h10,
        OPC_LB      = 6'h20, OPC_LH     = 6'h21, OPC_LWL  = 6'h22, OPC_LW    = 6'h23,
        OPC_LBU     = 6'h24, OPC_LHU    = 6'h25, OPC_LWR  = 6'h26,
        OPC_SB      = 6'h28, OPC_SH     = 6'h29, OPC_SWL  = 6'h2a, OPC_SW    = 6'h2b,
        OPC_SWR     = 6'h2e, OPC_CACHE  = 6'h2f
    } opcode_t;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA     = 6'h03,
        FN_JR   = 6'h08, FN_JALR = 6'h09, FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB     = 6'h22, FN_SUBU  = 6'h23,
        FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR     = 6'h26, FN_NOR   = 6'h27,
        FN_SLT  = 6'h2a
    } funct_t;

    // function field of COP0 with the CO bit set
    typedef enum logic [5:0] {
        CO_TLBWI = 6'h02,
        CO_TLBP  = 6'h08,
        CO_ERET  = 6'h18,
        CO_WAIT  = 6'h20
    } cop0_fn_t;

endpackage

//--- decoder/id_i.sv
`timescale 1ns/10ps
`include "mips_decode_consts.svh"

module id_i
    import mips_decode_pkg::*;
(
    input  logic [`INST_W-1:0] inst,
    output op_t                op,
    output logic [`REG_W-1:0]  reg_s,
    output logic [`REG_W-1:0]  reg_t,
    output logic [`IMM_W-1:0]  immediate,
    output logic               flag_unsigned
);

    opcode_t  opc;
    cop0_fn_t co_fn;

    assign opc       = opcode_t'(inst[`OPC_MSB:`OPC_LSB]);
    assign co_fn     = cop0_fn_t'(inst[5:0]);
    assign reg_s     = inst[25:21];
    assign reg_t     = inst[20:16];
    assign immediate = inst[`IMM_W-1:0];

    // addiu sltiu lbu lhu
    assign flag_unsigned = opc inside {OPC_ADDIU, OPC_SLTIU, OPC_LBU, OPC_LHU};

    always_comb begin
        op = OP_INVALID;
        case (opc)
            OPC_REGIMM: begin           // branch kind sits in rt
                case (reg_t)
                    5'h00:   op = OP_BLTZ;
                    5'h01:   op = OP_BGEZ;
                    5'h10:   op = OP_BLTZAL;
                    5'h11:   op = OP_BGEZAL;
                    default: op = OP_INVALID;
                endcase
            end
            OPC_BEQ:              op = OP_BEQ;
            OPC_BNE:              op = OP_BNE;
            OPC_BLEZ:             op = OP_BLEZ;
            OPC_BGTZ:             op = OP_BGTZ;
            OPC_ADDI, OPC_ADDIU:  op = OP_ADD;
            OPC_SLTI, OPC_SLTIU:  op = OP_SLT;
            OPC_ANDI:             op = OP_AND;
            OPC_ORI:              op = OP_OR;
            OPC_XORI:             op = OP_XOR;
            OPC_LUI:              op = OP_LU;
            OPC_COP0: begin
                if (reg_s == 5'h00)
                    op = OP_MFC0;
                else if (reg_s == 5'h04)
                    op = OP_MTC0;
                else if (reg_s[4]) begin    // CO form, pick by funct
                    case (co_fn)
                        CO_ERET:  op = OP_ERET;
                        CO_WAIT:  op = OP_WAIT;
                        CO_TLBWI: op = OP_TLBWI;
                        CO_TLBP:  op = OP_TLBP;
                        default:  op = OP_INVALID;
                    endcase
                end
            end
            OPC_LB, OPC_LBU:      op = OP_LB;
            OPC_LH, OPC_LHU:      op = OP_LH;
            OPC_LW:               op = OP_LW;
            OPC_LWL:              op = OP_LWL;
            OPC_LWR:              op = OP_LWR;
            OPC_SB:               op = OP_SB;
            OPC_SH:               op = OP_SH;
            OPC_SW:               op = OP_SW;
            OPC_SWL:              op = OP_SWL;
            OPC_SWR:              op = OP_SWR;
            OPC_CACHE:            op = OP_CACHE;
            default:              op = OP_INVALID;  // ll/sc and cop1/2 too
        endcase
    end

endmodule

//--- decoder/id_r.sv
`timescale 1ns/10ps
`include "mips_decode_consts.svh"

module id_r
    import mips_decode_pkg::*;
(
    input  logic [`INST_W-1:0]   inst,
    output op_t                  op,
    output logic [`REG_W-1:0]    reg_d,
    output logic [`SHAMT_W-1:0]  shamt
);

    funct_t fn;

    assign fn    = funct_t'(inst[5:0]);
    assign reg_d = inst[15:11];
    assign shamt = inst[10:6];

    always_comb begin
        case (fn)
            // overflow and unsigned forms share one op
            FN_ADD, FN_ADDU: op = OP_ADD;
            FN_SUB, FN_SUBU: op = OP_SUB;
            FN_AND:          op = OP_AND;
            FN_OR:           op = OP_OR;
            FN_XOR:          op = OP_XOR;
            FN_NOR:          op = OP_NOR;
            FN_SLT:          op = OP_SLT;
            // shifts by shamt
            FN_SLL:          op = OP_SLL;
            FN_SRL:          op = OP_SRL;
            FN_SRA:          op = OP_SRA;
            // register jumps
            FN_JR:           op = OP_JR;
            FN_JALR:         op = OP_JALR;
            // traps
            FN_SYSCALL:      op = OP_SYSCALL;
            FN_BREAK:        op = OP_BREAK;
            default:         op = OP_INVALID;  // sltu, mult, div etc
        endcase
    end

endmodule

//--- decoder/inst_decode.sv
`timescale 1ns/10ps
`include "mips_decode_consts.svh"

module inst_decode
    import mips_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`INST_W-1:0]    head,
    input  logic                  empty,
    output logic                  pop,
    input  logic                  out_ready,
    output logic                  out_valid,
    output op_t                   op,
    output logic [`REG_W-1:0]     reg_s,
    output logic [`REG_W-1:0]     reg_t,
    output logic [`REG_W-1:0]     reg_d,
    output logic [`SHAMT_W-1:0]   shamt,
    output logic [`IMM_W-1:0]     immediate,
    output logic [`JT_W-1:0]      jump_target,
    output logic                  flag_unsigned
);

    opcode_t             opc;
    op_t                 i_op;
    op_t                 r_op;
    op_t                 dec_op;
    logic [`REG_W-1:0]   i_reg_s;
    logic [`REG_W-1:0]   i_reg_t;
    logic [`REG_W-1:0]   r_reg_d;
    logic [`SHAMT_W-1:0] r_shamt;
    logic [`IMM_W-1:0]   i_imm;
    logic                i_unsigned;
    logic                dec_unsigned;

    id_i u_id_i (
        .inst          (head),
        .op            (i_op),
        .reg_s         (i_reg_s),
        .reg_t         (i_reg_t),
        .immediate     (i_imm),
        .flag_unsigned (i_unsigned)
    );

    id_r u_id_r (
        .inst  (head),
        .op    (r_op),
        .reg_d (r_reg_d),
        .shamt (r_shamt)
    );

    assign opc = opcode_t'(head[`OPC_MSB:`OPC_LSB]);

    // take a word when the output slot is free or draining
    assign pop = !empty && (!out_valid || out_ready);

    always_comb begin
        case (opc)
            OPC_SPECIAL: begin
                dec_op       = r_op;
                // addu/subu differ from add/sub in funct bit 0
                dec_unsigned = ((r_op == OP_ADD) || (r_op == OP_SUB)) && head[0];
            end
            OPC_J: begin
                dec_op       = OP_J;
                dec_unsigned = 1'b0;
            end
            OPC_JAL: begin
                dec_op       = OP_JAL;
                dec_unsigned = 1'b0;
            end
            default: begin
                dec_op       = i_op;
                dec_unsigned = i_unsigned;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (pop)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;    // taken, nothing behind it
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            op            <= dec_op;
            reg_s         <= i_reg_s;
            reg_t         <= i_reg_t;
            reg_d         <= r_reg_d;
            shamt         <= r_shamt;
            immediate     <= i_imm;
            jump_target   <= head[`JT_W-1:0];
            flag_unsigned <= dec_unsigned;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_decode -Mdir obj_dir \
    > sim.log 2>&1 && ./obj_dir/Vtb_decode >> sim.log 2>&1 || echo "Regression failed" >> sim.log
cat sim.log
if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

//--- verification/decode_asserts.sv
`timescale 1ns/10ps
`include "mips_decode_consts.svh"

module decode_asserts
    import mips_decode_pkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input logic [`APB_ADDR_W-1:0] paddr,
    input logic                   pready,
    input logic                   pslverr,
    input logic                   full,
    input logic                   out_ready,
    input logic                   out_valid,
    input op_t                    op,
    input logic [`REG_W-1:0]      reg_s,
    input logic [`REG_W-1:0]      reg_t,
    input logic [`REG_W-1:0]      reg_d,
    input logic [`SHAMT_W-1:0]    shamt,
    input logic [`IMM_W-1:0]      immediate,
    input logic [`JT_W-1:0]       jump_target,
    input logic                   flag_unsigned
);

    int fail_count = 0;

    // stalled output must not move
    hold_check: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(op) && $stable(reg_s)
            && $stable(reg_t) && $stable(reg_d) && $stable(shamt)
            && $stable(immediate) && $stable(jump_target) && $stable(flag_unsigned))
        else begin
            fail_count++;
            $error("decoded output changed while stalled");
        end

    backpressure_check: assert property (@(posedge clk) disable iff (reset)
        psel && penable && pwrite && (paddr == `APB_ADDR_INST) && full |-> !pready)
        else begin
            fail_count++;
            $error("instruction write completed into a full queue");
        end

    unsigned_check: assert property (@(posedge clk) disable iff (reset)
        out_valid && flag_unsigned |-> op inside {OP_ADD, OP_SUB, OP_SLT, OP_LB, OP_LH})
        else begin
            fail_count++;
            $error("unsigned flag on an op that has no unsigned form");
        end

    slverr_check: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (paddr != `APB_ADDR_INST) && (paddr != `APB_ADDR_STAT))
        else begin
            fail_count++;
            $error("slave error on a mapped address");
        end

endmodule

bind decode_subsys decode_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pready        (pready),
    .pslverr       (pslverr),
    .full          (full),
    .out_ready     (out_ready),
    .out_valid     (out_valid),
    .op            (op),
    .reg_s         (reg_s),
    .reg_t         (reg_t),
    .reg_d         (reg_d),
    .shamt         (shamt),
    .immediate     (immediate),
    .jump_target   (jump_target),
    .flag_unsigned (flag_unsigned)
);

//--- verification/tb_decode.sv
`timescale 1ns/10ps
`include "mips_decode_consts.svh"

module tb_decode;
    import mips_decode_pkg::*;

    localparam int WORDS = 74;               // words written over the whole run
    localparam int LIMIT = 40 * WORDS + 200;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        psel = 1'b0;
    logic        penable = 1'b0;
    logic        pwrite = 1'b0;
    logic [7:0]  paddr = '0;
    logic [31:0] pwdata = '0;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        out_ready = 1'b0;
    logic        out_valid;
    op_t         op;
    logic [4:0]  reg_s, reg_t, reg_d, shamt;
    logic [15:0] immediate;
    logic [25:0] jump_target;
    logic        flag_unsigned;

    int          seed = 29027;
    int          cycles = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    logic        rand_ready = 1'b0;
    logic [31:0] exp_words [$];

    logic [5:0] i_opcodes [30] = '{6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b,
        6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
        6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e, 6'h2f, 6'h11, 6'h12, 6'h30, 6'h38, 6'h27};
    logic [5:0] functs [17] = '{6'h00, 6'h02, 6'h03, 6'h08, 6'h09, 6'h0c, 6'h0d, 6'h20,
        6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};

    decode_subsys dut0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rand_ready) begin
            #1 out_ready = ($random(seed) % 4) != 0;
        end
    end

    function automatic op_t expected_op(input logic [31:0] w);
        logic [5:0] fn;
        fn = w[5:0];
        case (w[31:26])
            6'h00: case (fn)
                6'h20, 6'h21: return OP_ADD;
                6'h22, 6'h23: return OP_SUB;
                6'h24: return OP_AND;
                6'h25: return OP_OR;
                6'h26: return OP_XOR;
                6'h27: return OP_NOR;
                6'h2a: return OP_SLT;
                6'h00: return OP_SLL;
                6'h02: return OP_SRL;
                6'h03: return OP_SRA;
                6'h08: return OP_JR;
                6'h09: return OP_JALR;
                6'h0c: return OP_SYSCALL;
                6'h0d: return OP_BREAK;
                default: return OP_INVALID;
            endcase
            6'h01: case (w[20:16])
                5'h00: return OP_BLTZ;
                5'h01: return OP_BGEZ;
                5'h10: return OP_BLTZAL;
                5'h11: return OP_BGEZAL;
                default: return OP_INVALID;
            endcase
            6'h02: return OP_J;
            6'h03: return OP_JAL;
            6'h04: return OP_BEQ;
            6'h05: return OP_BNE;
            6'h06: return OP_BLEZ;
            6'h07: return OP_BGTZ;
            6'h08, 6'h09: return OP_ADD;
            6'h0a, 6'h0b: return OP_SLT;
            6'h0c: return OP_AND;
            6'h0d: return OP_OR;
            6'h0e: return OP_XOR;
            6'h0f: return OP_LU;
            6'h10: begin
                if (w[25:21] == 5'h00) return OP_MFC0;
                if (w[25:21] == 5'h04) return OP_MTC0;
                if (!w[25]) return OP_INVALID;   // CO bit
                case (fn)
                    6'h18: return OP_ERET;
                    6'h20: return OP_WAIT;
                    6'h02: return OP_TLBWI;
                    6'h08: return OP_TLBP;
                    default: return OP_INVALID;
                endcase
            end
            6'h20, 6'h24: return OP_LB;
            6'h21, 6'h25: return OP_LH;
            6'h22: return OP_LWL;
            6'h23: return OP_LW;
            6'h26: return OP_LWR;
            6'h28: return OP_SB;
            6'h29: return OP_SH;
            6'h2a: return OP_SWL;
            6'h2b: return OP_SW;
            6'h2e: return OP_SWR;
            6'h2f: return OP_CACHE;
            default: return OP_INVALID;
        endcase
    endfunction

    function automatic logic expected_unsigned(input logic [31:0] w);
        if (w[31:26] inside {6'h09, 6'h0b, 6'h24, 6'h25})
            return 1'b1;
        return (w[31:26] == 6'h00) && (w[5:0] inside {6'h21, 6'h23});
    endfunction

    task automatic compare(input string name, input int got, input int exp);
        assert (got == exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // output sink, sampled mid cycle where everything is settled
    always @(negedge clk) begin
        logic [31:0] w;
        if (!reset && out_valid && out_ready) begin
            if (exp_words.size() == 0) begin
                other_errors++;
                $display("output appeared with no word outstanding at %0t", $time);
            end else begin
                w = exp_words.pop_front();
                compare("op", op, expected_op(w));
                compare("reg_s", reg_s, w[25:21]);
                compare("reg_t", reg_t, w[20:16]);
                compare("reg_d", reg_d, w[15:11]);
                compare("shamt", shamt, w[10:6]);
                compare("immediate", immediate, w[15:0]);
                compare("jump_target", jump_target, w[25:0]);
                compare("flag_unsigned", flag_unsigned, expected_unsigned(w));
            end
        end
    end

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err, output int stalls);
        logic done;
        stalls = 0;
        @(posedge clk);
        #1 psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1 penable = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = pready;
            err = pslverr;
            rdata = prdata;
            if (!done)
                stalls++;
            @(posedge clk);
        end
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_inst(input logic [31:0] w, output int stalls);
        logic [31:0] rd;
        logic        err;
        exp_words.push_back(w);
        apb_xfer(1'b1, `APB_ADDR_INST, w, rd, err, stalls);
    endtask

    task automatic summary;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, other_errors, dut0.u_asserts.fail_count);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("run timed out after %0d cycles", cycles);
            summary();
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        int          st;
        int          total;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        out_ready = 1'b1;
        @(negedge clk);
        assert (!out_valid) else begin
            other_errors++;
            $display("out_valid high after reset");
        end

        // first word latency with an empty pipeline
        write_inst({6'h08, 5'd3, 5'd4, 16'h1234}, st);
        @(negedge clk);
        assert (!out_valid) else begin
            other_errors++;
            $display("first word out in the cycle its write completed");
        end
        @(negedge clk);
        assert (!out_valid) else begin
            other_errors++;
            $display("first word out one cycle after its write");
        end
        @(negedge clk);
        assert (out_valid) else begin
            other_errors++;
            $display("first word not out two cycles after its write");
        end

        rand_ready = 1'b1;
        foreach (i_opcodes[i])
            write_inst({i_opcodes[i], 5'($random(seed)), 5'($random(seed)),
                        16'($random(seed))}, st);
        write_inst({6'h01, 5'd1, 5'h00, 16'h0010}, st);
        write_inst({6'h01, 5'd2, 5'h01, 16'h0020}, st);
        write_inst({6'h01, 5'd3, 5'h10, 16'h0030}, st);
        write_inst({6'h01, 5'd4, 5'h11, 16'h0040}, st);
        write_inst({6'h01, 5'd5, 5'h02, 16'h0050}, st);   // unused rt
        write_inst({6'h10, 5'h00, 5'd7, 5'd12, 11'h0}, st);
        write_inst({6'h10, 5'h04, 5'd7, 5'd12, 11'h0}, st);
        write_inst({6'h10, 5'h10, 15'h0, 6'h18}, st);
        write_inst({6'h10, 5'h10, 15'h0, 6'h20}, st);
        write_inst({6'h10, 5'h10, 15'h0, 6'h02}, st);
        write_inst({6'h10, 5'h10, 15'h0, 6'h08}, st);
        write_inst({6'h10, 5'h10, 15'h0, 6'h01}, st);     // unknown co function
        write_inst({6'h10, 5'h01, 5'd7, 5'd12, 11'h0}, st);
        foreach (functs[i])
            write_inst({6'h00, 5'($random(seed)), 5'($random(seed)), 5'($random(seed)),
                        5'($random(seed)), functs[i]}, st);
        write_inst({6'h02, 26'($random(seed))}, st);
        write_inst({6'h03, 26'($random(seed))}, st);

        // fill queue and output register with the sink stopped
        while (exp_words.size() != 0)
            @(negedge clk);
        rand_ready = 1'b0;
        @(posedge clk);
        #1 out_ready = 1'b0;
        for (int i = 0; i < 9; i++)
            write_inst({6'h0d, 5'(i), 5'(i + 1), 16'(i * 3)}, st);
        apb_xfer(1'b0, `APB_ADDR_STAT, 32'h0, rd, err, st);
        compare("status count", rd, 8);
        fork
            begin
                write_inst({6'h0e, 5'd9, 5'd10, 16'hbeef}, st);
                assert (st > 0) else begin
                    other_errors++;
                    $display("write into a full queue did not stall");
                end
            end
            begin
                repeat (6) @(posedge clk);
                #1 out_ready = 1'b1;
            end
        join
        while (exp_words.size() != 0)
            @(negedge clk);

        // unmapped address
        apb_xfer(1'b1, 8'h08, 32'h2000_0001, rd, err, st);
        assert (err) else begin
            other_errors++;
            $display("write to unmapped address gave no slave error");
        end
        repeat (4) @(posedge clk);
        apb_xfer(1'b0, `APB_ADDR_STAT, 32'h0, rd, err, st);
        compare("status count", rd, 0);
        compare("status slverr", err, 0);

        repeat (4) @(posedge clk);
        total = mismatches + other_errors + dut0.u_asserts.fail_count;
        summary();
        if (total == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- verilog/apb_inst_port.sv
`timescale 1ns/10ps
`include "mips_decode_consts.svh"

module apb_inst_port
    import mips_decode_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`INST_W-1:0]     pwdata,
    output logic [`INST_W-1:0]     prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   full,
    input  logic [`QCNT_W-1:0]     count,
    output logic                   push,
    output logic [`INST_W-1:0]     push_data
);

    apb_state_t state;
    apb_state_t state_next;
    logic       access;
    logic       hit_inst;
    logic       hit_stat;
    logic       stall;

    assign hit_inst = (paddr == `APB_ADDR_INST);
    assign hit_stat = (paddr == `APB_ADDR_STAT);

    // access phase only counts once a setup cycle was seen
    assign access = psel && penable && (state != IDLE);
    assign stall  = hit_inst && pwrite && full;   // back-pressure

    assign pready    = access && !stall;
    assign pslverr   = access && !hit_inst && !hit_stat;
    assign push      = pready && pwrite && hit_inst;
    assign push_data = pwdata;

    always_comb begin
        prdata = '0;
        if (access && !pwrite && hit_stat)
            prdata[`QCNT_W-1:0] = count;
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (psel && !penable)
                    state_next = SETUP;
            end
            SETUP, ACCESS: begin
                if (!psel)
                    state_next = IDLE;
                else if (!penable)
                    state_next = SETUP;       // fresh transfer
                else if (pready)
                    state_next = IDLE;        // done this edge
                else
                    state_next = ACCESS;      // waiting on queue room
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

endmodule

//--- verilog/decode_subsys.sv
`timescale 1ns/10ps
`include "mips_decode_consts.svh"

module decode_subsys
    import mips_decode_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`INST_W-1:0]     pwdata,
    output logic [`INST_W-1:0]     prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   out_ready,
    output logic                   out_valid,
    output op_t                    op,
    output logic [`REG_W-1:0]      reg_s,
    output logic [`REG_W-1:0]      reg_t,
    output logic [`REG_W-1:0]      reg_d,
    output logic [`SHAMT_W-1:0]    shamt,
    output logic [`IMM_W-1:0]      immediate,
    output logic [`JT_W-1:0]       jump_target,
    output logic                   flag_unsigned
);

    logic               push;
    logic [`INST_W-1:0] push_data;
    logic               pop;
    logic [`INST_W-1:0] head;
    logic               empty;
    logic               full;
    logic [`QCNT_W-1:0] count;

    apb_inst_port u_port (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .full      (full),
        .count     (count),
        .push      (push),
        .push_data (push_data)
    );

    inst_queue #(
        .QUEUE_DEPTH (`QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full),
        .count     (count)
    );

    inst_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .head          (head),
        .empty         (empty),
        .pop           (pop),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .op            (op),
        .reg_s         (reg_s),
        .reg_t         (reg_t),
        .reg_d         (reg_d),
        .shamt         (shamt),
        .immediate     (immediate),
        .jump_target   (jump_target),
        .flag_unsigned (flag_unsigned)
    );

endmodule

//--- verilog/inst_queue.sv
`timescale 1ns/10ps
`include "mips_decode_consts.svh"

module inst_queue #(
    parameter int QUEUE_DEPTH = `QUEUE_DEPTH
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               push,
    input  logic [`INST_W-1:0]                 push_data,
    input  logic                               pop,
    output logic [`INST_W-1:0]                 head,
    output logic                               empty,
    output logic                               full,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0]   count
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [`INST_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               push_d;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == CNT_W'(QUEUE_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // newest entry becomes readable one cycle after its write
    assign empty = (count == '0) || ((count == CNT_W'(1)) && push_d);
    assign head  = mem[rd_ptr];   // show-ahead

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            push_d <= 1'b0;
        end else begin
            push_d <= do_push;
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none, or both at once
            endcase
        end
    end

endmodule

//--- vlog.f
+incdir+common
common/mips_decode_pkg.sv
decoder/id_i.sv
decoder/id_r.sv
decoder/inst_decode.sv
verilog/apb_inst_port.sv
verilog/inst_queue.sv
verilog/decode_subsys.sv
verification/decode_asserts.sv
verification/tb_decode.sv
